// ==== vlog.f ====
common/ex_ctrl_pkg.sv
common/ex_cp0_pkg.sv
alu/mul_div.sv
alu/alu.sv
hdl/cp0_write_mask.sv
hdl/ex_exception_check.sv
hdl/ex_stage.sv
verification/ex_stage_props.sv
verification/tb_ex_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_ex_stage -f vlog.f -o tb_ex_stage \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_ex_stage > sim.log 2>&1
grep -qF '** PASS **' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/tb_ex_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage
    import ex_ctrl_pkg::*, ex_cp0_pkg::*;
;

    localparam int N_ALU      = 160;
    localparam int N_MULDIV   = 60;
    localparam int N_FWD      = 60;
    localparam int N_CP0      = 60;
    localparam int N_LS       = 60;
    localparam int NUM_OPS    = N_ALU + N_MULDIV + N_FWD + N_CP0 + N_LS;
    localparam int MAX_CYCLES = NUM_OPS * (DIV_STEPS + 1) + 20;

    logic        clk;
    logic        reset;
    ex_ctrl_t    ctrl;
    ex_excp_t    excp_in;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] ext_imme;
    logic [4:0]  sa;
    logic [31:0] pc;
    fwd_sel_t    fwd_hi;
    fwd_sel_t    fwd_lo;
    logic [31:0] hilo_hi;
    logic [31:0] hilo_lo;
    logic [31:0] ls1_hi;
    logic [31:0] ls1_lo;
    logic [31:0] ls2_hi;
    logic [31:0] ls2_lo;
    logic [31:0] cp0_r_data;
    logic        ls1_cp0_ena;
    cp0_addr_u   ls1_cp0_addr;
    logic [31:0] ls1_cp0_data;
    logic [31:0] alu_res;
    logic [31:0] ls_addr;
    logic        ls_or;
    logic [31:0] hi_res;
    logic [31:0] lo_res;
    ex_ctrl_t    ctrl_out;
    logic [31:0] rt_out;
    logic [31:0] pc_out;
    ex_excp_t    excp_out;
    logic        has_exception;
    logic        cp0_r_ena;
    cp0_addr_u   cp0_r_addr;
    logic [31:0] cp0_w_data;
    logic        stall_req;

    logic [15:0] lfsr_state = 16'd39004;
    int          value_errors = 0;
    int          stall_errors = 0;
    int          cycle_count;
    int          i;
    int          stalls;
    int          want_stalls;
    ex_ctrl_t    c;
    ex_excp_t    e;
    ex_excp_t    exp_excp;
    logic [32:0] alu_exp;
    logic [63:0] exp64;
    logic [31:0] a_op;
    logic [31:0] b_op;
    logic [31:0] exp32;
    logic [31:0] hi_exp;
    logic [31:0] lo_exp;
    logic [31:0] addr;
    logic [2:0]  k;
    logic        bad;

    ex_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          b;
        v = 32'h0;
        for (b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // {overflow, result}
    function automatic logic [32:0] alu_model(input alu_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [32:0] wide;
        logic [32:0] diff;
        logic [63:0] ext;
        wide = {a[31], a} + {b[31], b};
        diff = {a[31], a} - {b[31], b};
        ext  = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            ALU_ADD:  return {wide[32] ^ wide[31], wide[31:0]};
            ALU_ADDU: return {1'b0, a + b};
            ALU_SUB:  return {diff[32] ^ diff[31], diff[31:0]};
            ALU_SUBU: return {1'b0, a - b};
            ALU_AND:  return {1'b0, a & b};
            ALU_OR:   return {1'b0, a | b};
            ALU_XOR:  return {1'b0, a ^ b};
            ALU_NOR:  return {1'b0, ~(a | b)};
            ALU_SLT:  return {32'h0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ALU_SLTU: return {32'h0, a < b};
            ALU_SLL:  return {1'b0, a << b[4:0]};
            ALU_SRL:  return {1'b0, a >> b[4:0]};
            ALU_SRA:  return {1'b0, ext[31:0]};
            ALU_LUI:  return {1'b0, b[15:0], 16'h0};
            default:  return 33'h0;
        endcase
    endfunction

    // {hi, lo}
    function automatic logic [63:0] muldiv_model(input alu_op_t op, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic               sgn;
        logic signed [63:0] xa;
        logic signed [63:0] xb;
        logic signed [63:0] q;
        logic signed [63:0] r;
        sgn = (op == ALU_MULT) || (op == ALU_DIV);
        xa  = sgn ? {{32{a[31]}}, a} : {32'h0, a};
        xb  = sgn ? {{32{b[31]}}, b} : {32'h0, b};
        if (op == ALU_MULT || op == ALU_MULTU) begin
            return xa * xb;
        end
        if (b == 32'h0) begin
            return {a, 32'hffff_ffff};
        end
        // 64-bit signed divide truncates toward zero
        q = xa / xb;
        r = xa % xb;
        return {r[31:0], q[31:0]};
    endfunction

    function automatic logic [31:0] cp0_mask_model(input logic [7:0] a, input logic [31:0] d);
        logic [31:0] m;
        if (a[2:0] != 3'd0) begin
            return 32'h0;
        end
        case (a[7:3])
            CP0_BADVADDR, CP0_COUNT, CP0_COMPARE, CP0_EPC: m = 32'hffff_ffff;
            CP0_STATUS:                 m = 32'h0000_ff03;
            CP0_CAUSE:                  m = 32'h0000_0300;
            CP0_INDEX:                  m = 32'h0000_000f;
            CP0_ENTRYLO0, CP0_ENTRYLO1: m = 32'h03ff_ffff;
            CP0_ENTRYHI:                m = 32'hffff_e0ff;
            default:                    m = 32'h0;
        endcase
        return d & m;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        value_errors++;
    endtask

    // fields the stage hands on unchanged
    task automatic check_passthrough(input ex_ctrl_t cv);
        if (ctrl_out !== cv) report_mismatch("ctrl_out", 64'(ctrl_out), 64'(cv));
        if (rt_out !== rt_data) report_mismatch("rt_out", rt_out, rt_data);
        if (pc_out !== pc) report_mismatch("pc_out", pc_out, pc);
    endtask

    task automatic load_random_data();
        rs_data          <= rand_bits(32);
        rt_data          <= rand_bits(32);
        ext_imme         <= rand_bits(32);
        sa               <= 5'(rand_bits(5));
        pc               <= rand_bits(32);
        fwd_hi           <= 3'(rand_bits(2) % 3);
        fwd_lo           <= 3'(rand_bits(2) % 3);
        hilo_hi          <= rand_bits(32);
        hilo_lo          <= rand_bits(32);
        ls1_hi           <= rand_bits(32);
        ls1_lo           <= rand_bits(32);
        ls2_hi           <= rand_bits(32);
        ls2_lo           <= rand_bits(32);
        cp0_r_data       <= rand_bits(32);
        ls1_cp0_ena      <= 1'(rand_bits(1));
        ls1_cp0_addr.raw <= 8'(rand_bits(8));
        ls1_cp0_data     <= rand_bits(32);
    endtask

    task automatic apply_inputs(input ex_ctrl_t cv, input ex_excp_t ev);
        @(posedge clk);
        ctrl    <= cv;
        excp_in <= ev;
        load_random_data();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        reset   <= 1'b1;
        ctrl    <= '0;
        excp_in <= '0;
        load_random_data();
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // single-cycle alu ops and overflow
        for (i = 0; i < N_ALU; i++) begin
            c = '0;
            c.src_a_sel = 3'(rand_bits(2) % 3);
            c.src_b_sel = 3'(rand_bits(3) % 5);
            c.alu_op    = 6'(rand_bits(4) % 14);
            c.check_ov  = 1'(rand_bits(1));
            apply_inputs(c, '0);
            @(negedge clk);
            a_op = (c.src_a_sel == SRC_A_RS) ? rs_data :
                   ((c.src_a_sel == SRC_A_RT) ? rt_data : 32'h0);
            case (c.src_b_sel)
                SRC_B_RT:   b_op = rt_data;
                SRC_B_RS:   b_op = rs_data;
                SRC_B_IMME: b_op = ext_imme;
                SRC_B_SA:   b_op = {27'h0, sa};
                default:    b_op = 32'h0;
            endcase
            alu_exp = alu_model(c.alu_op, a_op, b_op);
            exp_excp = '0;
            exp_excp.overflow = alu_exp[32] & c.check_ov;
            if (alu_res !== alu_exp[31:0]) report_mismatch("alu_res", alu_res, alu_exp[31:0]);
            if (excp_out !== exp_excp) report_mismatch("excp_out", 32'(excp_out), 32'(exp_excp));
            if (has_exception !== exp_excp.overflow) begin
                report_mismatch("has_exception", 32'(has_exception), 32'(exp_excp.overflow));
            end
            if (ls_addr !== 32'h0) report_mismatch("ls_addr", ls_addr, 32'h0);
            check_passthrough(c);
        end

        // multiply and divide, held while stalled
        for (i = 0; i < N_MULDIV; i++) begin
            c = '0;
            c.src_a_sel = SRC_A_RS;
            c.src_b_sel = SRC_B_RT;
            c.alu_op    = ALU_MULT + 6'(rand_bits(2));
            apply_inputs(c, '0);
            if (rand_bits(3) == 0) rt_data <= 32'h0;
            @(negedge clk);
            stalls = 0;
            while (stall_req) begin
                stalls++;
                @(negedge clk);
            end
            want_stalls = (c.alu_op == ALU_MULT || c.alu_op == ALU_MULTU) ? 1 : DIV_STEPS;
            if (stalls != want_stalls) begin
                $display("Error at %0t ns: stall_req held %0d cycles for alu_op %0d, expected %0d",
                         $time, stalls, c.alu_op, want_stalls);
                stall_errors++;
            end
            exp64 = muldiv_model(c.alu_op, rs_data, rt_data);
            if (hi_res !== exp64[63:32]) report_mismatch("hi_res", hi_res, exp64[63:32]);
            if (lo_res !== exp64[31:0]) report_mismatch("lo_res", lo_res, exp64[31:0]);
            check_passthrough(c);
        end

        // hi/lo forwarding and pc+8
        for (i = 0; i < N_FWD; i++) begin
            c = '0;
            c.alu_op      = ALU_ADDU;
            c.alu_res_sel = 3'(rand_bits(2) % 3 + 1);
            apply_inputs(c, '0);
            @(negedge clk);
            hi_exp = (fwd_hi == FWD_LS2) ? ls2_hi : ((fwd_hi == FWD_LS1) ? ls1_hi : hilo_hi);
            lo_exp = (fwd_lo == FWD_LS2) ? ls2_lo : ((fwd_lo == FWD_LS1) ? ls1_lo : hilo_lo);
            case (c.alu_res_sel)
                RES_HI:  exp32 = hi_exp;
                RES_LO:  exp32 = lo_exp;
                default: exp32 = pc + 32'd8;
            endcase
            if (alu_res !== exp32) report_mismatch("alu_res", alu_res, exp32);
            if (cp0_r_ena !== 1'b0) report_mismatch("cp0_r_ena", 32'(cp0_r_ena), 32'h0);
            check_passthrough(c);
        end

        // cp0 read bypass and write mask
        for (i = 0; i < N_CP0; i++) begin
            c = '0;
            c.alu_op           = ALU_ADDU;
            c.alu_res_sel      = RES_CP0;
            c.w_cp0_ena        = 1'(rand_bits(1));
            c.w_cp0_addr[7:3]  = 5'(rand_bits(5));
            c.w_cp0_addr[2:0]  = (rand_bits(1) == 1) ? 3'(rand_bits(3)) : 3'h0;
            apply_inputs(c, '0);
            if (rand_bits(1) == 1) ls1_cp0_addr.raw <= c.w_cp0_addr;
            @(negedge clk);
            exp32 = (ls1_cp0_ena && ls1_cp0_addr.raw == c.w_cp0_addr) ? ls1_cp0_data : cp0_r_data;
            if (alu_res !== exp32) report_mismatch("alu_res", alu_res, exp32);
            if (cp0_r_ena !== 1'b1) report_mismatch("cp0_r_ena", 32'(cp0_r_ena), 32'h1);
            if (cp0_r_addr.raw !== c.w_cp0_addr) begin
                report_mismatch("cp0_r_addr", 32'(cp0_r_addr.raw), 32'(c.w_cp0_addr));
            end
            exp32 = cp0_mask_model(c.w_cp0_addr, rt_data);
            if (cp0_w_data !== exp32) report_mismatch("cp0_w_data", cp0_w_data, exp32);
            check_passthrough(c);
        end

        // load/store address and alignment
        for (i = 0; i < N_LS; i++) begin
            c = '0;
            c.src_a_sel = SRC_A_RS;
            c.src_b_sel = SRC_B_IMME;
            c.alu_op    = ALU_ADDU;
            c.ls_ena    = 1'b1;
            k = 3'(rand_bits(3));
            c.ls_sel = (k < 3'd5) ? 4'(k) : 4'(k) + 4'd3;
            e = (rand_bits(1) == 1) ? 10'(rand_bits(10)) : 10'h0;
            apply_inputs(c, e);
            @(negedge clk);
            addr = rs_data + ext_imme;
            bad = ((c.ls_sel == LS_LH || c.ls_sel == LS_LHU || c.ls_sel == LS_SH) && addr[0]) ||
                  ((c.ls_sel == LS_LW || c.ls_sel == LS_SW) && addr[1:0] != 2'b00);
            exp_excp = e;
            exp_excp.data_adel = e.data_adel | (bad & ~c.ls_sel[3]);
            exp_excp.data_ades = e.data_ades | (bad & c.ls_sel[3]);
            if (ls_addr !== addr) report_mismatch("ls_addr", ls_addr, addr);
            if (ls_or !== c.ls_sel[3]) report_mismatch("ls_or", 32'(ls_or), 32'(c.ls_sel[3]));
            if (excp_out !== exp_excp) report_mismatch("excp_out", 32'(excp_out), 32'(exp_excp));
            if (has_exception !== (|exp_excp[8:0])) begin
                report_mismatch("has_exception", 32'(has_exception), 32'(|exp_excp[8:0]));
            end
            check_passthrough(c);
        end

        @(posedge clk);
        $display("Done: %0d value errors, %0d stall errors", value_errors, stall_errors);
        if (value_errors == 0 && stall_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/ex_stage_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_stage_props
    import ex_ctrl_pkg::*, ex_cp0_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input ex_ctrl_t ctrl,
    input ex_excp_t excp_in,
    input logic     has_exception,
    input logic     stall_req
);

    logic       is_div;
    logic [6:0] div_stalls;

    assign is_div = (ctrl.alu_op == ALU_DIV) || (ctrl.alu_op == ALU_DIVU);

    // divide stall cycles seen so far in a row
    always_ff @(posedge clk) begin
        if (reset || !(stall_req && is_div)) begin
            div_stalls <= 7'h0;
        end else begin
            div_stalls <= div_stalls + 7'h1;
        end
    end

    stall_low_after_reset: assert property (@(posedge clk) reset |=> !stall_req)
        else $error("stall_req is high in the cycle after reset");

    // in_delay_slot sits in bit 9 and does not count
    exception_has_flag: assert property (@(posedge clk) disable iff (reset)
        has_exception |-> ((|excp_in[8:0]) || ctrl.ls_ena || ctrl.check_ov))
        else $error("has_exception is set while no exception flag or check is active");

    div_stall_bounded: assert property (@(posedge clk) disable iff (reset)
        (stall_req && is_div) |-> (div_stalls < 7'(DIV_STEPS)))
        else $error("divide stall lasts longer than DIV_STEPS cycles");

endmodule

bind ex_stage ex_stage_props u_props (
    .clk           (clk),
    .reset         (reset),
    .ctrl          (ctrl),
    .excp_in       (excp_in),
    .has_exception (has_exception),
    .stall_req     (stall_req)
);

`default_nettype wire

// ==== hdl/ex_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_stage
    import ex_ctrl_pkg::*, ex_cp0_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  ex_ctrl_t    ctrl,
    input  ex_excp_t    excp_in,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    input  logic [31:0] ext_imme,
    input  logic [4:0]  sa,
    input  logic [31:0] pc,
    input  fwd_sel_t    fwd_hi,
    input  fwd_sel_t    fwd_lo,
    input  logic [31:0] hilo_hi,
    input  logic [31:0] hilo_lo,
    input  logic [31:0] ls1_hi,
    input  logic [31:0] ls1_lo,
    input  logic [31:0] ls2_hi,
    input  logic [31:0] ls2_lo,
    input  logic [31:0] cp0_r_data,
    input  logic        ls1_cp0_ena,
    input  cp0_addr_u   ls1_cp0_addr,
    input  logic [31:0] ls1_cp0_data,
    output logic [31:0] alu_res,
    output logic [31:0] ls_addr,
    output logic        ls_or,
    output logic [31:0] hi_res,
    output logic [31:0] lo_res,
    output ex_ctrl_t    ctrl_out,
    output logic [31:0] rt_out,
    output logic [31:0] pc_out,
    output ex_excp_t    excp_out,
    output logic        has_exception,
    output logic        cp0_r_ena,
    output cp0_addr_u   cp0_r_addr,
    output logic [31:0] cp0_w_data,
    output logic        stall_req
);

    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] alu_out;
    logic        alu_ov;
    logic [31:0] hi_fw;
    logic [31:0] lo_fw;
    logic [31:0] cp0_data;
    cp0_addr_u   cp0_addr;

    function automatic logic [31:0] fwd_pick(input fwd_sel_t sel, input logic [31:0] rf,
                                             input logic [31:0] s1, input logic [31:0] s2);
        case (sel)
            FWD_LS1: fwd_pick = s1;
            FWD_LS2: fwd_pick = s2;
            default: fwd_pick = rf;
        endcase
    endfunction

    always_comb begin
        case (ctrl.src_a_sel)
            SRC_A_RS: src_a = rs_data;
            SRC_A_RT: src_a = rt_data;
            default:  src_a = 32'h0;
        endcase
        case (ctrl.src_b_sel)
            SRC_B_RT:   src_b = rt_data;
            SRC_B_RS:   src_b = rs_data;
            SRC_B_IMME: src_b = ext_imme;
            SRC_B_SA:   src_b = {27'h0, sa};
            default:    src_b = 32'h0;
        endcase
    end

    assign hi_fw = fwd_pick(fwd_hi, hilo_hi, ls1_hi, ls2_hi);
    assign lo_fw = fwd_pick(fwd_lo, hilo_lo, ls1_lo, ls2_lo);

    // mfc0 reads the same address field that mtc0 writes
    assign cp0_addr   = ctrl.w_cp0_addr;
    assign cp0_r_addr = cp0_addr;
    assign cp0_r_ena  = (ctrl.alu_res_sel == RES_CP0);
    // pending write one stage ahead wins
    assign cp0_data   = (ls1_cp0_ena && ls1_cp0_addr.raw == cp0_addr.raw) ?
                        ls1_cp0_data : cp0_r_data;

    always_comb begin
        case (ctrl.alu_res_sel)
            RES_ALU: alu_res = alu_out;
            RES_HI:  alu_res = hi_fw;
            RES_LO:  alu_res = lo_fw;
            RES_PC8: alu_res = pc + 32'h8;
            RES_CP0: alu_res = cp0_data;
            default: alu_res = 32'h0;
        endcase
    end

    assign ls_addr  = ctrl.ls_ena ? (rs_data + ext_imme) : 32'h0;
    assign ls_or    = ctrl.ls_sel[3];
    assign ctrl_out = ctrl;
    assign rt_out   = rt_data;
    assign pc_out   = pc;

    alu u_alu (
        .clk       (clk),
        .reset     (reset),
        .src_a     (src_a),
        .src_b     (src_b),
        .alu_op    (ctrl.alu_op),
        .alu_res   (alu_out),
        .overflow  (alu_ov),
        .hi_res    (hi_res),
        .lo_res    (lo_res),
        .stall_req (stall_req)
    );

    ex_exception_check u_excp (
        .excp_in       (excp_in),
        .ls_ena        (ctrl.ls_ena),
        .ls_sel        (ctrl.ls_sel),
        .ls_addr       (ls_addr[1:0]),
        .check_ov      (ctrl.check_ov),
        .overflow      (alu_ov),
        .excp_out      (excp_out),
        .has_exception (has_exception)
    );

    cp0_write_mask u_cp0_mask (
        .w_addr  (cp0_addr),
        .rt_data (rt_data),
        .w_data  (cp0_w_data)
    );

endmodule

`default_nettype wire

// ==== hdl/ex_exception_check.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_exception_check
    import ex_ctrl_pkg::*, ex_cp0_pkg::*;
(
    input  ex_excp_t   excp_in,
    input  logic       ls_ena,
    input  ls_sel_t    ls_sel,
    input  logic [1:0] ls_addr,
    input  logic       check_ov,
    input  logic       overflow,
    output ex_excp_t   excp_out,
    output logic       has_exception
);

    logic half_bad;
    logic word_bad;

    assign half_bad = ls_addr[0];
    assign word_bad = |ls_addr;

    always_comb begin
        excp_out = excp_in;
        excp_out.data_adel = excp_in.data_adel | (ls_ena &&
            (((ls_sel == LS_LH || ls_sel == LS_LHU) && half_bad) ||
             (ls_sel == LS_LW && word_bad)));
        excp_out.data_ades = excp_in.data_ades | (ls_ena &&
            ((ls_sel == LS_SH && half_bad) || (ls_sel == LS_SW && word_bad)));
        // unsigned ops leave check_ov low
        excp_out.overflow  = excp_in.overflow | (overflow & check_ov);
    end

    // delay slot is a qualifier, not an exception
    assign has_exception = excp_out.eret | excp_out.syscall | excp_out.brk |
                           excp_out.inst_adel | excp_out.ri | excp_out.intr |
                           excp_out.data_adel | excp_out.data_ades |
                           excp_out.overflow;

endmodule

`default_nettype wire

// ==== hdl/cp0_write_mask.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0_write_mask
    import ex_cp0_pkg::*;
(
    input  cp0_addr_u   w_addr,
    input  logic [31:0] rt_data,
    output logic [31:0] w_data
);

    always_comb begin
        w_data = 32'h0;
        // only select 0 registers are writable
        if (w_addr.f.sel == 3'd0) begin
            case (w_addr.f.reg_num)
                CP0_BADVADDR, CP0_COUNT, CP0_COMPARE, CP0_EPC: begin
                    w_data = rt_data;
                end
                CP0_STATUS: begin
                    // interrupt mask, exl and ie
                    w_data[15:8] = rt_data[15:8];
                    w_data[1:0]  = rt_data[1:0];
                end
                CP0_CAUSE: begin
                    // software interrupts
                    w_data[9:8] = rt_data[9:8];
                end
                CP0_INDEX: begin
                    w_data[3:0] = rt_data[3:0];
                end
                CP0_ENTRYLO0, CP0_ENTRYLO1: begin
                    w_data[25:0] = rt_data[25:0];
                end
                CP0_ENTRYHI: begin
                    // vpn2 and asid
                    w_data[31:13] = rt_data[31:13];
                    w_data[7:0]   = rt_data[7:0];
                end
                default: begin
                    w_data = 32'h0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== alu/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu
    import ex_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] src_a,
    input  logic [31:0] src_b,
    input  alu_op_t     alu_op,
    output logic [31:0] alu_res,
    output logic        overflow,
    output logic [31:0] hi_res,
    output logic [31:0] lo_res,
    output logic        stall_req
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shamt;

    assign sum   = src_a + src_b;
    assign diff  = src_a - src_b;
    // shifts move src_a by the low bits of src_b
    assign shamt = src_b[4:0];

    always_comb begin
        alu_res  = 32'h0;
        overflow = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                alu_res  = sum;
                overflow = (src_a[31] == src_b[31]) && (sum[31] != src_a[31]);
            end
            ALU_ADDU: alu_res = sum;
            ALU_SUB: begin
                alu_res  = diff;
                overflow = (src_a[31] != src_b[31]) && (diff[31] != src_a[31]);
            end
            ALU_SUBU: alu_res = diff;
            ALU_AND:  alu_res = src_a & src_b;
            ALU_OR:   alu_res = src_a | src_b;
            ALU_XOR:  alu_res = src_a ^ src_b;
            ALU_NOR:  alu_res = ~(src_a | src_b);
            ALU_SLT:  alu_res = {31'h0, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: alu_res = {31'h0, src_a < src_b};
            ALU_SLL:  alu_res = src_a << shamt;
            ALU_SRL:  alu_res = src_a >> shamt;
            ALU_SRA:  alu_res = $signed(src_a) >>> shamt;
            ALU_LUI:  alu_res = {src_b[15:0], 16'h0};
            // mult/div results come back on hi/lo only
            default:  alu_res = 32'h0;
        endcase
    end

    mul_div u_mul_div (
        .clk       (clk),
        .reset     (reset),
        .a         (src_a),
        .b         (src_b),
        .alu_op    (alu_op),
        .hi        (hi_res),
        .lo        (lo_res),
        .stall_req (stall_req)
    );

endmodule

`default_nettype wire

// ==== alu/mul_div.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_div
    import ex_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_t     alu_op,
    output logic [31:0] hi,
    output logic [31:0] lo,
    output logic        stall_req
);

    logic               is_mul;
    logic               is_div;
    logic               is_signed;
    logic               busy;
    logic               done;
    logic               div_last;
    logic [5:0]         count;
    logic [31:0]        rem_q;
    logic [31:0]        quo_q;
    logic [31:0]        abs_a;
    logic [31:0]        abs_b;
    logic [31:0]        step_rem;
    logic [31:0]        step_quo;
    logic [32:0]        shifted;
    logic [32:0]        trial;
    logic [31:0]        rem_next;
    logic [31:0]        quo_next;
    logic [31:0]        quo_fix;
    logic [31:0]        rem_fix;
    logic signed [63:0] prod_s;
    logic [63:0]        prod_u;

    assign is_mul    = (alu_op == ALU_MULT) || (alu_op == ALU_MULTU);
    assign is_div    = (alu_op == ALU_DIV) || (alu_op == ALU_DIVU);
    assign is_signed = (alu_op == ALU_MULT) || (alu_op == ALU_DIV);
    // held low once the presented op has finished
    assign stall_req = (is_mul || is_div) && !done;

    assign prod_s = $signed(a) * $signed(b);
    assign prod_u = {32'h0, a} * {32'h0, b};

    assign abs_a = (is_signed && a[31]) ? -a : a;
    assign abs_b = (is_signed && b[31]) ? -b : b;

    // first step runs straight off the dividend
    assign step_rem = busy ? rem_q : 32'h0;
    assign step_quo = busy ? quo_q : abs_a;

    assign shifted  = {step_rem, step_quo[31]};
    assign trial    = shifted - {1'b0, abs_b};
    assign rem_next = trial[32] ? shifted[31:0] : trial[31:0];
    assign quo_next = {step_quo[30:0], ~trial[32]};

    assign quo_fix  = (is_signed && (a[31] ^ b[31])) ? -quo_next : quo_next;
    assign rem_fix  = (is_signed && a[31]) ? -rem_next : rem_next;
    assign div_last = busy && (count == 6'(DIV_STEPS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= 6'h0;
        end else if (done) begin
            done <= 1'b0;
        end else if (is_mul) begin
            done <= 1'b1;
        end else if (is_div) begin
            if (!busy) begin
                busy  <= 1'b1;
                count <= 6'h1;
            end else if (div_last) begin
                busy  <= 1'b0;
                done  <= 1'b1;
                count <= 6'h0;
            end else begin
                count <= count + 6'h1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!done && is_mul) begin
            {hi, lo} <= is_signed ? prod_s : prod_u;
        end else if (!done && is_div) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
            if (div_last) begin
                if (b == 32'h0) begin
                    // divide by zero, defined result
                    hi <= a;
                    lo <= 32'hffff_ffff;
                end else begin
                    hi <= rem_fix;
                    lo <= quo_fix;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/ex_cp0_pkg.sv ====
`default_nettype none

package ex_cp0_pkg;

    // cp0 register numbers, select 0
    localparam logic [4:0] CP0_INDEX    = 5'd0;
    localparam logic [4:0] CP0_ENTRYLO0 = 5'd2;
    localparam logic [4:0] CP0_ENTRYLO1 = 5'd3;
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_COUNT    = 5'd9;
    localparam logic [4:0] CP0_ENTRYHI  = 5'd10;
    localparam logic [4:0] CP0_COMPARE  = 5'd11;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    typedef struct packed {
        logic [4:0] reg_num;
        logic [2:0] sel;
    } cp0_field_t;

    // whole address for compares, split view for decoding
    typedef union packed {
        logic [7:0] raw;
        cp0_field_t f;
    } cp0_addr_u;

    typedef struct packed {
        logic in_delay_slot;
        logic eret;
        logic syscall;
        logic brk;
        logic inst_adel;
        logic ri;
        logic intr;
        logic data_adel;
        logic data_ades;
        logic overflow;
    } ex_excp_t;

endpackage

`default_nettype wire

// ==== common/ex_ctrl_pkg.sv ====
`default_nettype none

package ex_ctrl_pkg;

    // operand A source
    typedef logic [2:0] src_a_sel_t;
    localparam src_a_sel_t SRC_A_ZERO = 3'd0;
    localparam src_a_sel_t SRC_A_RS   = 3'd1;
    localparam src_a_sel_t SRC_A_RT   = 3'd2;

    // operand B source
    typedef logic [2:0] src_b_sel_t;
    localparam src_b_sel_t SRC_B_ZERO = 3'd0;
    localparam src_b_sel_t SRC_B_RT   = 3'd1;
    localparam src_b_sel_t SRC_B_RS   = 3'd2;
    localparam src_b_sel_t SRC_B_IMME = 3'd3;
    localparam src_b_sel_t SRC_B_SA   = 3'd4;

    typedef logic [5:0] alu_op_t;
    localparam alu_op_t ALU_ADD   = 6'd0;
    localparam alu_op_t ALU_ADDU  = 6'd1;
    localparam alu_op_t ALU_SUB   = 6'd2;
    localparam alu_op_t ALU_SUBU  = 6'd3;
    localparam alu_op_t ALU_AND   = 6'd4;
    localparam alu_op_t ALU_OR    = 6'd5;
    localparam alu_op_t ALU_XOR   = 6'd6;
    localparam alu_op_t ALU_NOR   = 6'd7;
    localparam alu_op_t ALU_SLT   = 6'd8;
    localparam alu_op_t ALU_SLTU  = 6'd9;
    localparam alu_op_t ALU_SLL   = 6'd10;
    localparam alu_op_t ALU_SRL   = 6'd11;
    localparam alu_op_t ALU_SRA   = 6'd12;
    localparam alu_op_t ALU_LUI   = 6'd13;
    localparam alu_op_t ALU_MULT  = 6'd14;
    localparam alu_op_t ALU_MULTU = 6'd15;
    localparam alu_op_t ALU_DIV   = 6'd16;
    localparam alu_op_t ALU_DIVU  = 6'd17;

    typedef logic [2:0] alu_res_sel_t;
    localparam alu_res_sel_t RES_ALU = 3'd0;
    localparam alu_res_sel_t RES_HI  = 3'd1;
    localparam alu_res_sel_t RES_LO  = 3'd2;
    localparam alu_res_sel_t RES_PC8 = 3'd3;
    localparam alu_res_sel_t RES_CP0 = 3'd4;

    // bit 3 set means store
    typedef logic [3:0] ls_sel_t;
    localparam ls_sel_t LS_LB  = 4'b0000;
    localparam ls_sel_t LS_LBU = 4'b0001;
    localparam ls_sel_t LS_LH  = 4'b0010;
    localparam ls_sel_t LS_LHU = 4'b0011;
    localparam ls_sel_t LS_LW  = 4'b0100;
    localparam ls_sel_t LS_SB  = 4'b1000;
    localparam ls_sel_t LS_SH  = 4'b1001;
    localparam ls_sel_t LS_SW  = 4'b1010;

    // hi/lo forward source
    typedef logic [2:0] fwd_sel_t;
    localparam fwd_sel_t FWD_HILO = 3'd0;
    localparam fwd_sel_t FWD_LS1  = 3'd1;
    localparam fwd_sel_t FWD_LS2  = 3'd2;

    typedef struct packed {
        src_a_sel_t   src_a_sel;
        src_b_sel_t   src_b_sel;
        alu_op_t      alu_op;
        alu_res_sel_t alu_res_sel;
        logic         w_reg_ena;
        logic [4:0]   w_reg_dst;
        logic [1:0]   w_hilo_ena;
        logic         w_cp0_ena;
        logic [7:0]   w_cp0_addr;
        logic         ls_ena;
        ls_sel_t      ls_sel;
        logic         wb_reg_sel;
        logic         check_ov;
    } ex_ctrl_t;

    localparam int DIV_STEPS = 32;

endpackage

`default_nettype wire
